//--- files.f
src/debug_pkg.sv
src/bin2bcd.sv
src/debug_msg_builder.sv
src/debug_tx_seq.sv
src/debug_cmd_decoder.sv
src/debug_console.sv
tb/debug_console_asserts.sv
tb/tb_debug_console.sv

//--- run.sh
#!/bin/sh
# Build and run the debug console testbench with Verilator
# Exit status 0 only when the log holds the pass line

cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=obj_dir/sim_debug_console

verilator --binary --timing --assert -j 0 \
  -f files.f \
  --top-module tb_debug_console \
  -Mdir obj_dir -o sim_debug_console
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"$SIM" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "Finished with no errors" "$LOG"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1

//--- src/bin2bcd.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Binary to packed BCD converter
// Combinational double dabble, any width
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module bin2bcd #(
  parameter int BITS   = 24,
  parameter int DIGITS = 8
) (
  input  logic [BITS-1:0]     bin,
  output logic [4*DIGITS-1:0] bcd
);

  // BCD digits on top, binary shifted out of the bottom
  logic [4*DIGITS+BITS-1:0] scratch;

  always_comb begin
    scratch = '0;
    scratch[BITS-1:0] = bin;

    // One pass per input bit
    for (int i = 0; i < BITS; i++) begin
      // Digits of 5 or more would overflow on the shift
      for (int d = 0; d < DIGITS; d++) begin
        if (scratch[BITS+4*d +: 4] >= 4'd5) begin
          scratch[BITS+4*d +: 4] = scratch[BITS+4*d +: 4] + 4'd3;
        end
      end
      scratch = scratch << 1;
    end

    // Binary part is all zeros by now
    bcd = scratch[BITS +: 4*DIGITS];
  end

endmodule

//--- src/debug_cmd_decoder.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Terminal command decoder
// Motor and logging flags, board reset pulse
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module debug_cmd_decoder import debug_pkg::*; (
  input  logic          clk,
  input  logic          rst,
  input  logic [7:0]    rx_data,
  input  logic          new_rx_data,
  output status_flags_t flags,
  output logic          board_rst
);

  cmd_state_e state;
  cmd_state_e state_next;

  // Only idle accepts a new byte
  always_comb begin
    state_next = CMD_IDLE;
    if (state == CMD_IDLE && new_rx_data) begin
      case (rx_data)
        CMD_RESET: state_next = CMD_DO_RESET;
        CMD_MOTOR: state_next = CMD_DO_MOTOR;
        CMD_DATA:  state_next = CMD_DO_DATA;
        // Anything else is not a command
        default:   state_next = CMD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state              <= CMD_IDLE;
      flags.motor_armed  <= 1'b0;
      flags.data_logging <= 1'b0;
      board_rst          <= 1'b0;
    end else begin
      state <= state_next;

      // Action states last one cycle
      board_rst <= (state == CMD_DO_RESET);

      // Arm or disarm
      if (state == CMD_DO_MOTOR) begin
        flags.motor_armed <= ~flags.motor_armed;
      end

      // Start or stop recording
      if (state == CMD_DO_DATA) begin
        flags.data_logging <= ~flags.data_logging;
      end
    end
  end

endmodule

//--- src/debug_console.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Debug console top level
// Command decoder, line sequencer, line builder
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module debug_console import debug_pkg::*; #(
  parameter int TS_BITS   = 24,
  parameter int TS_DIGITS = 8
) (
  input  logic          clk,
  input  logic          rst,
  input  logic          tmr,
  input  sensor_frame_t frame,
  input  logic [7:0]    rx_data,
  input  logic          new_rx_data,
  input  logic          tx_busy,
  output logic [7:0]    tx_data,
  output logic          new_tx_data,
  output logic          board_rst
);

  // Flags from the command side
  status_flags_t flags;

  // Captured line and current position
  line_snapshot_t          snap;
  logic [MSG_IDX_BITS-1:0] char_idx;

  // Terminal input
  debug_cmd_decoder u_cmd (
    .clk         (clk),
    .rst         (rst),
    .rx_data     (rx_data),
    .new_rx_data (new_rx_data),
    .flags       (flags),
    .board_rst   (board_rst)
  );

  // Tick-driven line sequencing
  debug_tx_seq u_seq (
    .clk         (clk),
    .rst         (rst),
    .tmr         (tmr),
    .tx_busy     (tx_busy),
    .frame       (frame),
    .flags       (flags),
    .snap        (snap),
    .char_idx    (char_idx),
    .new_tx_data (new_tx_data)
  );

  // Character for the current index
  debug_msg_builder #(
    .TS_BITS   (TS_BITS),
    .TS_DIGITS (TS_DIGITS)
  ) u_msg (
    .snap     (snap),
    .char_idx (char_idx),
    .tx_data  (tx_data)
  );

endmodule

//--- src/debug_msg_builder.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Debug line character mux
// Maps a character index and a snapshot
// to one ASCII byte of the line
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module debug_msg_builder import debug_pkg::*; #(
  parameter int TS_BITS   = 24,
  parameter int TS_DIGITS = 8
) (
  input  line_snapshot_t          snap,
  input  logic [MSG_IDX_BITS-1:0] char_idx,
  output logic [7:0]              tx_data
);

  // Timestamp in decimal
  logic [TS_BITS-1:0]     ts_bin;
  logic [4*TS_DIGITS-1:0] ts_bcd;

  // Accelerometer field position decode
  logic [5:0] acc_off;
  logic [2:0] acc_grp;
  logic [3:0] acc_pos;
  logic [5:0] acc_bit;

  assign ts_bin = TS_BITS'(snap.frame.timestamp);

  bin2bcd #(
    .BITS   (TS_BITS),
    .DIGITS (TS_DIGITS)
  ) u_ts_bcd (
    .bin (ts_bin),
    .bcd (ts_bcd)
  );

  // Field starts at 7, nine columns per group
  // Column 8 of each group is the separating space
  assign acc_off = char_idx - 6'd7;
  assign acc_grp = 3'(acc_off / 6'd9);
  assign acc_pos = 4'(acc_off % 6'd9);

  // MSB first, group 0 holds bits 47..40
  assign acc_bit = 6'd47 - {acc_grp, 3'b000} - {2'b00, acc_pos};

  always_comb begin
    case (char_idx) inside
      // Timestamp shown as d5 d4 d3 . d2
      6'd1:
        tx_data = 8'h30 + {4'h0, ts_bcd[23:20]};
      6'd2:
        tx_data = 8'h30 + {4'h0, ts_bcd[19:16]};
      6'd3:
        tx_data = 8'h30 + {4'h0, ts_bcd[15:12]};
      6'd4:
        tx_data = ".";
      6'd5:
        tx_data = 8'h30 + {4'h0, ts_bcd[11:8]};

      // Binary groups with spaces between
      [6'd7:6'd59]: begin
        if (acc_pos == 4'd8) begin
          tx_data = " ";
        end else begin
          tx_data = snap.frame.acc[acc_bit] ? "1" : "0";
        end
      end

      // Status letters
      6'd61:
        tx_data = snap.flags.motor_armed ? "A" : "D";
      6'd62:
        tx_data = snap.flags.data_logging ? "R" : "I";

      // End of line
      6'd63:
        tx_data = 8'h0d;

      // Leading space and field separators at 0, 6, 60
      default:
        tx_data = " ";
    endcase
  end

endmodule

//--- src/debug_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Debug console shared types
// Line layout constants, command bytes,
// snapshot structs and FSM state enums
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package debug_pkg;

  // Fixed line layout, 64 characters
  localparam int MSG_LEN      = 64;
  localparam int MSG_IDX_BITS = 6;

  // Command bytes from the serial bridge
  localparam logic [7:0] CMD_RESET = "r";
  localparam logic [7:0] CMD_MOTOR = "m";
  localparam logic [7:0] CMD_DATA  = "d";

  // Board status shown at the end of each line
  typedef struct packed {
    logic motor_armed;
    logic data_logging;
  } status_flags_t;

  // Sensor inputs as sampled from the board
  typedef struct packed {
    logic [23:0] timestamp;
    logic [47:0] acc;
  } sensor_frame_t;

  // Everything one line needs, frozen at line start
  typedef struct packed {
    sensor_frame_t frame;
    status_flags_t flags;
  } line_snapshot_t;

  // Transmit sequencer states
  typedef enum logic {
    TX_IDLE,
    TX_SEND
  } tx_state_e;

  // Command decoder states
  typedef enum logic [1:0] {
    CMD_IDLE,
    CMD_DO_RESET,
    CMD_DO_MOTOR,
    CMD_DO_DATA
  } cmd_state_e;

endpackage

//--- src/debug_tx_seq.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Debug line transmit sequencer
// Snapshot capture on tick, index stepping
// under bridge back-pressure
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module debug_tx_seq import debug_pkg::*; (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    tmr,
  input  logic                    tx_busy,
  input  sensor_frame_t           frame,
  input  status_flags_t           flags,
  output line_snapshot_t          snap,
  output logic [MSG_IDX_BITS-1:0] char_idx,
  output logic                    new_tx_data
);

  tx_state_e state;
  logic      start;
  logic      last_char;

  // Ticks during a line are dropped
  assign start     = (state == TX_IDLE) && tmr;
  assign last_char = (char_idx == MSG_IDX_BITS'(MSG_LEN - 1));

  // Byte goes out whenever the bridge can take it
  assign new_tx_data = (state == TX_SEND) && !tx_busy;

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= TX_IDLE;
      char_idx <= '0;
    end else begin
      case (state)
        TX_IDLE: begin
          if (start) begin
            state    <= TX_SEND;
            char_idx <= '0;
          end
        end
        TX_SEND: begin
          // Index holds while busy
          if (new_tx_data) begin
            char_idx <= char_idx + 1'b1;
            if (last_char) begin
              state <= TX_IDLE;
            end
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  // Frozen line contents, so a line is always coherent
  always_ff @(posedge clk) begin
    if (start) begin
      snap.frame <= frame;
      snap.flags <= flags;
    end
  end

endmodule

//--- tb/debug_console_asserts.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Transmit and command protocol assertions
// Bound into the sequencer and the decoder
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module debug_console_asserts (
  input logic clk,
  input logic rst,
  input logic new_tx_data,
  input logic tx_busy,
  input logic board_rst
);

  // Bridge busy means no byte is handed over
  a_no_strobe_when_busy: assert property (
    @(posedge clk) disable iff (rst) !(new_tx_data && tx_busy)
  ) else $error("new_tx_data high while tx_busy high");

  // Board reset is a single-cycle pulse
  a_board_rst_one_cycle: assert property (
    @(posedge clk) disable iff (rst) board_rst |=> !board_rst
  ) else $error("board_rst held high for more than one cycle");

  // Sequencer comes out of reset idle
  a_quiet_after_reset: assert property (
    @(posedge clk) $fell(rst) |-> !new_tx_data
  ) else $error("new_tx_data high in the first cycle after reset");

endmodule

// Transmit side, no reset pulse here
bind debug_tx_seq debug_console_asserts u_tx_asserts (
  .clk         (clk),
  .rst         (rst),
  .new_tx_data (new_tx_data),
  .tx_busy     (tx_busy),
  .board_rst   (1'b0)
);

// Command side, no bridge strobes here
bind debug_cmd_decoder debug_console_asserts u_cmd_asserts (
  .clk         (clk),
  .rst         (rst),
  .new_tx_data (1'b0),
  .tx_busy     (1'b0),
  .board_rst   (board_rst)
);

//--- tb/debug_patterns.txt
# T timestamp acc busy : one line, timestamp and acc in hex, busy 0 none or 1 random
# C byte : command byte in hex ; S ts acc ts2 acc2 : second frame and tick mid-line
# Power-up flags, bridge always ready
T 01E240 A5F00F3C81FF 0
T 0F1206 0123456789AB 0
# Random back-pressure
T 0F1206 0123456789AB 1
T FFFFFF 800000000001 1
# Frame change and tick during a line
S 00002A FFFFFFFFFFFF 098967 000000000000
# Motor armed, junk byte in between
C 6D
C 78
T 0003E8 C3C3C3C3C3C3 0
# Logging on, upper-case M is not a command
C 64
C 4D
T 002710 00FF00FF00FF 1
# Motor disarmed again
C 31
C 6D
T 0186A0 F0F0F0F0F0F0 0
# Board reset pulse, flags stay as they are
C 72
T 0F423F 123456789ABC 0

//--- tb/tb_debug_console.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Debug console testbench
// Pattern reader, line and command tests,
// reference line model, cycle watchdog
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module tb_debug_console import debug_pkg::*; ();

  // One pattern line after parsing
  typedef struct packed {
    logic [7:0]    op;
    logic [7:0]    cmd;
    logic          busy;
    sensor_frame_t frame;
    sensor_frame_t alt;
  } pattern_t;

  logic          clk = 1'b0;
  logic          rst;
  logic          tmr;
  sensor_frame_t frame;
  logic [7:0]    rx_data;
  logic          new_rx_data;
  logic          tx_busy;
  logic [7:0]    tx_data;
  logic          new_tx_data;
  logic          board_rst;

  pattern_t   pats[$];
  logic [7:0] exp_line [MSG_LEN];
  logic [7:0] got_line [MSG_LEN];
  logic       motor_model;
  logic       logging_model;
  integer     seed;
  int         errors;
  int         tests_run;
  int         tests_failed;
  int         n_lines;
  int         cycles = 0;
  int         cycle_limit = 0;

  debug_console #(
    .TS_BITS   (24),
    .TS_DIGITS (8)
  ) UUT (
    .clk         (clk),
    .rst         (rst),
    .tmr         (tmr),
    .frame       (frame),
    .rx_data     (rx_data),
    .new_rx_data (new_rx_data),
    .tx_busy     (tx_busy),
    .tx_data     (tx_data),
    .new_tx_data (new_tx_data),
    .board_rst   (board_rst)
  );

  // 8 ns clock
  always #4 clk = ~clk;

  // Watchdog, limit set once the patterns are known
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles, a line never completed", cycles);
      $display("Finished with errors");
      $finish;
    end
  end

  task automatic read_patterns();
    int                 fd;
    int                 code;
    logic [7:0]         op;
    logic [8*128-1:0]   rest;
    logic [23:0]        ts;
    logic [23:0]        ts2;
    logic [47:0]        acc;
    logic [47:0]        acc2;
    logic [31:0]        val;
    pattern_t           p;
    fd = $fopen("tb/debug_patterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open the pattern file tb/debug_patterns.txt");
      errors++;
      return;
    end
    forever begin
      code = $fscanf(fd, " %c", op);
      if (code != 1) break;
      p = '0;
      p.op = op;
      case (op)
        // Comment, drop rest of line
        "#": code = $fgets(rest, fd);
        "T": begin
          code = $fscanf(fd, "%h %h %h", ts, acc, val);
          p.frame = '{timestamp: ts, acc: acc};
          p.busy = val[0];
          n_lines += 1;
        end
        "S": begin
          code = $fscanf(fd, "%h %h %h %h", ts, acc, ts2, acc2);
          p.frame = '{timestamp: ts, acc: acc};
          p.alt = '{timestamp: ts2, acc: acc2};
          n_lines += 2;
        end
        "C": begin
          code = $fscanf(fd, "%h", val);
          p.cmd = val[7:0];
        end
        default: begin
          $display("Unknown operation in the pattern file");
          errors++;
        end
      endcase
      if (op != "#") pats.push_back(p);
    end
    $fclose(fd);
  endtask

  function automatic logic [7:0] digit_char(input int v);
    return 8'(48 + v % 10);
  endfunction

  // Expected line straight from the layout rules
  task automatic build_expected(input sensor_frame_t f);
    int ts;
    int pos;
    ts = int'(f.timestamp);
    exp_line[0] = " ";
    exp_line[1] = digit_char(ts / 100000);
    exp_line[2] = digit_char(ts / 10000);
    exp_line[3] = digit_char(ts / 1000);
    exp_line[4] = ".";
    exp_line[5] = digit_char(ts / 100);
    exp_line[6] = " ";
    pos = 7;
    for (int g = 0; g < 6; g++) begin
      if (g > 0) begin
        exp_line[pos] = " ";
        pos++;
      end
      for (int b = 0; b < 8; b++) begin
        exp_line[pos] = f.acc[47 - 8 * g - b] ? "1" : "0";
        pos++;
      end
    end
    exp_line[60] = " ";
    exp_line[61] = motor_model ? "A" : "D";
    exp_line[62] = logging_model ? "R" : "I";
    exp_line[63] = 8'h0d;
  endtask

  // Tick one line out and compare all 64 bytes
  task automatic run_line(input sensor_frame_t f, input logic busy_rand,
                          input logic mid_change, input sensor_frame_t alt);
    int   n;
    int   extra;
    int   rnd;
    logic changed;
    logic busy_hit;
    n = 0;
    extra = 0;
    changed = 1'b0;
    busy_hit = 1'b0;
    build_expected(f);
    frame = f;
    tmr = 1'b1;
    while (n < MSG_LEN) begin
      #1;
      if (new_tx_data) begin
        if (tx_busy) busy_hit = 1'b1;
        got_line[n] = tx_data;
        n++;
      end
      @(negedge clk);
      tmr = 1'b0;
      rnd = $random(seed);
      tx_busy = busy_rand & rnd[0];
      // New frame and a stray tick in mid-line
      if (mid_change && !changed && n == 20) begin
        frame = alt;
        tmr = 1'b1;
        changed = 1'b1;
      end
    end
    // Line must stop at 64
    tx_busy = 1'b0;
    repeat (6) begin
      #1;
      if (new_tx_data) extra++;
      @(negedge clk);
    end
    for (int i = 0; i < MSG_LEN; i++) begin
      assert (got_line[i] == exp_line[i]) else begin
        $display("Fail tx_data at index %0d: expected %h, got %h", i, exp_line[i],
                 got_line[i]);
        errors++;
      end
    end
    assert (!busy_hit) else begin
      $display("A strobe was given while tx_busy was high");
      errors++;
    end
    assert (extra == 0) else begin
      $display("Strobes kept coming after the last character of the line");
      errors++;
    end
  endtask

  // Single byte from the bridge
  task automatic run_command(input logic [7:0] cmd);
    int pulses;
    int expected;
    pulses = 0;
    expected = (cmd == "r") ? 1 : 0;
    rx_data = cmd;
    new_rx_data = 1'b1;
    @(negedge clk);
    new_rx_data = 1'b0;
    repeat (6) begin
      if (board_rst) pulses++;
      @(negedge clk);
    end
    if (cmd == "m") motor_model = ~motor_model;
    if (cmd == "d") logging_model = ~logging_model;
    assert (pulses == expected) else begin
      $display("Fail board_rst pulse count: expected %h, got %h", expected, pulses);
      errors++;
    end
  endtask

  task automatic check_idle();
    repeat (20) begin
      assert (!new_tx_data && !board_rst) else begin
        $display("Fail idle outputs {new_tx_data, board_rst}: expected 0, got %h",
                 {new_tx_data, board_rst});
        errors++;
      end
      @(negedge clk);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("Test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: FAILED", tests_run, name);
    end
  endtask

  task automatic run_pattern(input pattern_t p);
    int    errs_before;
    string name;
    errs_before = errors;
    name = "unknown";
    case (p.op)
      "T": begin
        name = $sformatf("line ts %h busy %0d", p.frame.timestamp, p.busy);
        run_line(p.frame, p.busy, 1'b0, p.frame);
      end
      "S": begin
        name = $sformatf("mid-line change ts %h to %h", p.frame.timestamp,
                         p.alt.timestamp);
        run_line(p.frame, 1'b0, 1'b1, p.alt);
        run_line(p.alt, 1'b0, 1'b0, p.alt);
      end
      "C": begin
        name = $sformatf("command byte %h", p.cmd);
        run_command(p.cmd);
      end
      default: name = "unknown operation";
    endcase
    report_test(name, errs_before);
  endtask

  initial begin
    int errs_before;
    seed = 32'hea4245b0;
    rst = 1'b1;
    tmr = 1'b0;
    frame = '0;
    rx_data = 8'h00;
    new_rx_data = 1'b0;
    tx_busy = 1'b0;
    motor_model = 1'b0;
    logging_model = 1'b0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    n_lines = 0;
    read_patterns();
    cycle_limit = n_lines * MSG_LEN * 4 + 200;
    repeat (4) @(negedge clk);
    rst = 1'b0;
    errs_before = errors;
    check_idle();
    report_test("idle after reset", errs_before);
    foreach (pats[i]) run_pattern(pats[i]);
    $display("Tests run %0d, passed %0d, failed %0d, check errors %0d", tests_run,
             tests_run - tests_failed, tests_failed, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule
